/* src.f */
design/cpuPkg.sv
design/alu.sv
design/fetchUnit.sv
design/instrQueue.sv
design/executeUnit.sv
design/accCpu.sv
bench/accCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= accCpuTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/accCpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module accCpuTb;

    // table size and run limit
    localparam int numRows = 28;
    localparam int cyclesPerRow = 64;
    localparam int cycleLimit = numRows * cyclesPerRow;

    typedef enum logic [1:0] {
        aluKind   = 2'd0,
        jumpKind  = 2'd1,
        storeKind = 2'd2
    } rowKindE;

    // one test program with its two data words
    typedef struct packed {
        rowKindE             kind;
        cpuPkg::instrT [7:0] prog;
        cpuPkg::wordT        d0;
        cpuPkg::wordT        d1;
    } rowT;

    logic         clk;
    logic         arstN;
    logic         loadEn;
    logic         loadSel;
    cpuPkg::addrT loadAddr;
    cpuPkg::wordT loadData;
    logic         start;
    logic         halted;
    cpuPkg::wordT acc;

    rowT rows [numRows];
    int  seed;
    int  cycles;

    accCpu i_accCpu (
        .clk      (clk),
        .arstN    (arstN),
        .loadEn   (loadEn),
        .loadSel  (loadSel),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .start    (start),
        .halted   (halted),
        .acc      (acc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit over the whole table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic compareAcc(input cpuPkg::wordT got, input cpuPkg::wordT exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: acc %s, got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compareHalted(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: halted %s, got %b expected %b", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic cpuPkg::wordT randWord();
        return cpuPkg::wordT'($random(seed));
    endfunction

    function automatic cpuPkg::instrT makeInstr(cpuPkg::instrOpE op, cpuPkg::aluOpE aluOp,
                                                cpuPkg::addrT field);
        cpuPkg::instrT ins;
        ins.op = op;
        ins.aluOp = aluOp;
        ins.field = field;
        return ins;
    endfunction

    // alu behavior taken from the operation list
    function automatic cpuPkg::wordT aluModel(cpuPkg::aluOpE op, cpuPkg::wordT a,
                                              cpuPkg::wordT b);
        logic [31:0]  prod;
        cpuPkg::wordT r;
        prod = {16'h0000, a} * {16'h0000, b};
        case (op)
            cpuPkg::ADD:  r = a + b;
            cpuPkg::SUB:  r = a - b;
            cpuPkg::MUL:  r = prod[15:0];
            cpuPkg::DIV:  r = (b == 16'h0000) ? 16'hffff : a / b;
            cpuPkg::SHL:  r = {a[14:0], 1'b0};
            cpuPkg::SHR:  r = {1'b0, a[15:1]};
            cpuPkg::ROL:  r = (a << 1) | (a >> 15);
            cpuPkg::ROR:  r = (a >> 1) | (a << 15);
            cpuPkg::AND:  r = a & b;
            cpuPkg::OR:   r = a | b;
            cpuPkg::XOR:  r = a ^ b;
            cpuPkg::NOR:  r = ~(a | b);
            cpuPkg::NAND: r = ~(a & b);
            cpuPkg::XNOR: r = ~(a ^ b);
            cpuPkg::GT:   r = (a > b) ? 16'd1 : 16'd0;
            default:      r = (a == b) ? 16'd1 : 16'd0;
        endcase
        return r;
    endfunction

    // instruction level model, runs until halt
    function automatic cpuPkg::wordT runModel(rowT row);
        cpuPkg::wordT  mem [256];
        cpuPkg::wordT  a;
        cpuPkg::instrT ins;
        int            pc;
        int            steps;
        logic          done;
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        mem[0] = row.d0;
        mem[1] = row.d1;
        a = '0;
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 64) begin
            ins = row.prog[pc % 8];
            pc = pc + 1;
            steps++;
            case (ins.op)
                cpuPkg::LOADI: a = cpuPkg::wordT'(ins.field);
                cpuPkg::LOAD:  a = mem[ins.field];
                cpuPkg::STORE: mem[ins.field] = a;
                cpuPkg::ALUM:  a = aluModel(ins.aluOp, a, mem[ins.field]);
                cpuPkg::JUMP:  pc = int'(ins.field);
                cpuPkg::JUMPZ: begin
                    if (a == '0) begin
                        pc = int'(ins.field);
                    end
                end
                cpuPkg::HALT:  done = 1'b1;
                default:       done = 1'b0;
            endcase
        end
        return a;
    endfunction

    // load addr 0, alum with addr 1, halt
    function automatic rowT aluRow(cpuPkg::aluOpE op, cpuPkg::wordT a, cpuPkg::wordT b);
        rowT r;
        r = '0;
        r.kind = aluKind;
        r.prog[0] = makeInstr(cpuPkg::LOAD, cpuPkg::ADD, 8'd0);
        r.prog[1] = makeInstr(cpuPkg::ALUM, op, 8'd1);
        r.prog[2] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        r.d0 = a;
        r.d1 = b;
        return r;
    endfunction

    task automatic buildTable();
        int           n;
        cpuPkg::wordT w;
        rowT          r;
        n = 0;
        // every alu op with random operands
        for (int k = 0; k < 16; k++) begin
            rows[n] = aluRow(cpuPkg::aluOpE'(k), randWord(), randWord());
            n++;
        end
        // edge rows
        rows[n] = aluRow(cpuPkg::DIV, randWord(), 16'h0000);
        n++;
        w = randWord();
        rows[n] = aluRow(cpuPkg::EQ, w, w);
        n++;
        rows[n] = aluRow(cpuPkg::GT, w, w);
        n++;
        rows[n] = aluRow(cpuPkg::SHL, 16'h8001, randWord());
        n++;
        rows[n] = aluRow(cpuPkg::SHR, 16'h8001, randWord());
        n++;
        rows[n] = aluRow(cpuPkg::ROL, 16'hc000, randWord());
        n++;
        rows[n] = aluRow(cpuPkg::ROR, 16'h0003, randWord());
        n++;
        // store then reload through addr 5
        r = '0;
        r.kind = storeKind;
        r.prog[0] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, cpuPkg::addrT'(randWord()));
        r.prog[1] = makeInstr(cpuPkg::STORE, cpuPkg::ADD, 8'd5);
        r.prog[2] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd0);
        r.prog[3] = makeInstr(cpuPkg::LOAD, cpuPkg::ADD, 8'd5);
        r.prog[4] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        rows[n] = r;
        n++;
        // jump over a loadi
        r = '0;
        r.kind = jumpKind;
        r.prog[0] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd1);
        r.prog[1] = makeInstr(cpuPkg::JUMP, cpuPkg::ADD, 8'd3);
        r.prog[2] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd9);
        r.prog[3] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        rows[n] = r;
        n++;
        // jumpz taken, target sets 7
        r = '0;
        r.kind = jumpKind;
        r.prog[0] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd0);
        r.prog[1] = makeInstr(cpuPkg::JUMPZ, cpuPkg::ADD, 8'd3);
        r.prog[2] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd9);
        r.prog[3] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd7);
        r.prog[4] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        rows[n] = r;
        n++;
        // jumpz not taken, falls into loadi 9
        r = '0;
        r.kind = jumpKind;
        r.prog[0] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd2);
        r.prog[1] = makeInstr(cpuPkg::JUMPZ, cpuPkg::ADD, 8'd3);
        r.prog[2] = makeInstr(cpuPkg::LOADI, cpuPkg::ADD, 8'd9);
        r.prog[3] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        rows[n] = r;
        n++;
        // chained alum ops, queue fills during memwait
        r = aluRow(cpuPkg::ADD, randWord(), randWord());
        r.prog[2] = makeInstr(cpuPkg::ALUM, cpuPkg::MUL, 8'd1);
        r.prog[3] = makeInstr(cpuPkg::ALUM, cpuPkg::XOR, 8'd1);
        r.prog[4] = makeInstr(cpuPkg::ALUM, cpuPkg::SUB, 8'd1);
        r.prog[5] = makeInstr(cpuPkg::ALUM, cpuPkg::ROL, 8'd1);
        r.prog[6] = makeInstr(cpuPkg::ALUM, cpuPkg::OR, 8'd1);
        r.prog[7] = makeInstr(cpuPkg::HALT, cpuPkg::ADD, 8'd0);
        rows[n] = r;
    endtask

    // one host write per cycle, caller drops loadEn
    task automatic loadWord(input logic sel, input cpuPkg::addrT addr,
                            input cpuPkg::wordT data);
        @(negedge clk);
        loadEn = 1'b1;
        loadSel = sel;
        loadAddr = addr;
        loadData = data;
    endtask

    task automatic applyRow(input int idx);
        string what;
        what = $sformatf("row %0d (%s)", idx, rows[idx].kind.name());
        for (int k = 0; k < 8; k++) begin
            loadWord(1'b0, cpuPkg::addrT'(k), cpuPkg::wordT'(rows[idx].prog[k]));
        end
        loadWord(1'b1, 8'd0, rows[idx].d0);
        loadWord(1'b1, 8'd1, rows[idx].d1);
        // start pulse right after the last write
        @(negedge clk);
        loadEn = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // start clears halted on its edge
        compareHalted(halted, 1'b0, what);
        while (!halted) begin
            @(negedge clk);
        end
        compareAcc(acc, runModel(rows[idx]), what);
    endtask

    initial begin
        arstN = 1'b0;
        loadEn = 1'b0;
        loadSel = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start = 1'b0;
        cycles = 0;
        seed = 312;
        buildTable();
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        compareHalted(halted, 1'b0, "after reset");
        compareAcc(acc, 16'h0000, "after reset");
        for (int r = 0; r < numRows; r++) begin
            applyRow(r);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/accCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module accCpu (
    input  logic         clk,
    input  logic         arstN,
    // host load port
    input  logic         loadEn,
    input  logic         loadSel,
    input  cpuPkg::addrT loadAddr,
    input  cpuPkg::wordT loadData,
    input  logic         start,
    output logic         halted,
    output cpuPkg::wordT acc
);

    logic               progWe;
    logic               dataWe;
    logic               flush;
    logic               run;
    logic               stop;
    logic               redirect;
    cpuPkg::addrT       redirectAddr;
    logic               fetchValid;
    logic               fetchReady;
    cpuPkg::queueEntryT fetchEntry;
    logic               issueValid;
    logic               issueReady;
    cpuPkg::queueEntryT issueEntry;

    // sel 0 is program memory and sel 1 is data memory
    assign progWe = loadEn && !loadSel;
    assign dataWe = loadEn && loadSel;

    // queue empties on jumps and on start or halt
    assign flush = redirect || run || stop;

    fetchUnit i_fetchUnit (
        .clk          (clk),
        .arstN        (arstN),
        .progWe       (progWe),
        .progAddr     (loadAddr),
        .progData     (loadData),
        .run          (run),
        .stop         (stop),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .fetchValid   (fetchValid),
        .fetchEntry   (fetchEntry),
        .fetchReady   (fetchReady)
    );

    instrQueue i_instrQueue (
        .clk        (clk),
        .arstN      (arstN),
        .flush      (flush),
        .fetchValid (fetchValid),
        .fetchEntry (fetchEntry),
        .fetchReady (fetchReady),
        .issueValid (issueValid),
        .issueEntry (issueEntry),
        .issueReady (issueReady)
    );

    executeUnit i_executeUnit (
        .clk          (clk),
        .arstN        (arstN),
        .start        (start),
        .dataWe       (dataWe),
        .dataAddr     (loadAddr),
        .dataData     (loadData),
        .issueValid   (issueValid),
        .issueEntry   (issueEntry),
        .issueReady   (issueReady),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .run          (run),
        .stop         (stop),
        .halted       (halted),
        .acc          (acc)
    );

endmodule

`default_nettype wire

/* design/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               start,
    // host data writes
    input  logic               dataWe,
    input  cpuPkg::addrT       dataAddr,
    input  cpuPkg::wordT       dataData,
    // consumer side of the queue
    input  logic               issueValid,
    input  cpuPkg::queueEntryT issueEntry,
    output logic               issueReady,
    // back to fetch and queue
    output logic               redirect,
    output cpuPkg::addrT       redirectAddr,
    output logic               run,
    output logic               stop,
    // host status
    output logic               halted,
    output cpuPkg::wordT       acc
);

    cpuPkg::execStateE state;

    // data store, 256 words
    cpuPkg::wordT dataMem [2**cpuPkg::addrWidth];
    cpuPkg::wordT memQ;

    cpuPkg::instrT curInstr;
    // instruction parked across memwait
    cpuPkg::instrT pendInstr;
    cpuPkg::wordT  aluResult;

    logic         accept;
    logic         memRead;
    logic         storeEn;
    logic         memWe;
    cpuPkg::addrT memWAddr;
    cpuPkg::wordT memWData;
    cpuPkg::addrT nextAddr;

    assign curInstr   = issueEntry.instr;
    // stall the queue while waiting on memory
    assign issueReady = (state == cpuPkg::RUN);
    assign accept     = issueValid && issueReady;

    // start only counts from idle or halted
    assign run    = start && (state == cpuPkg::IDLE || state == cpuPkg::HALTED);
    assign stop   = accept && (curInstr.op == cpuPkg::HALT);
    assign halted = (state == cpuPkg::HALTED);

    // untaken jumpz falls through quietly
    assign redirect = accept && ((curInstr.op == cpuPkg::JUMP) ||
                      (curInstr.op == cpuPkg::JUMPZ && acc == '0));
    assign redirectAddr = curInstr.field;

    assign memRead = accept && (curInstr.op == cpuPkg::LOAD || curInstr.op == cpuPkg::ALUM);
    assign storeEn = accept && (curInstr.op == cpuPkg::STORE);

    // host only writes while stopped so one write port is enough
    assign memWe    = dataWe || storeEn;
    assign memWAddr = storeEn ? curInstr.field : dataAddr;
    assign memWData = storeEn ? acc : dataData;

    alu i_alu (
        .op       (pendInstr.aluOp),
        .operandA (acc),
        .operandB (memQ),
        .result   (aluResult)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::IDLE;
            acc   <= '0;
        end else begin
            case (state)
                cpuPkg::IDLE, cpuPkg::HALTED: begin
                    if (start) begin
                        state <= cpuPkg::RUN;
                    end
                end
                cpuPkg::RUN: begin
                    if (accept) begin
                        case (curInstr.op)
                            // immediate is zero extended
                            cpuPkg::LOADI: acc <= cpuPkg::wordT'(curInstr.field);
                            cpuPkg::LOAD, cpuPkg::ALUM: state <= cpuPkg::MEMWAIT;
                            cpuPkg::HALT: state <= cpuPkg::HALTED;
                            // nop, jumps, store and unknown codes
                            default: state <= cpuPkg::RUN;
                        endcase
                    end
                end
                cpuPkg::MEMWAIT: begin
                    // memory word now in memQ
                    if (pendInstr.op == cpuPkg::LOAD) begin
                        acc <= memQ;
                    end else begin
                        acc <= aluResult;
                    end
                    state <= cpuPkg::RUN;
                end
                default: state <= cpuPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (memWe) begin
            dataMem[memWAddr] <= memWData;
        end
        if (memRead) begin
            memQ      <= dataMem[curInstr.field];
            pendInstr <= curInstr;
        end
    end

    // fetch address the next accepted entry must carry
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextAddr <= '0;
        end else if (run) begin
            nextAddr <= '0;
        end else if (redirect) begin
            nextAddr <= redirectAddr;
        end else if (accept) begin
            nextAddr <= issueEntry.fetchAddr + 1'b1;
        end
    end

    // no jump can leave a stopped machine
    assert property (@(posedge clk) disable iff (!arstN)
        (state == cpuPkg::IDLE || state == cpuPkg::HALTED) |-> !redirect);

    // entries reach execute in program order, none lost or repeated
    assert property (@(posedge clk) disable iff (!arstN)
        accept |-> issueEntry.fetchAddr == nextAddr);

    // host loads must not race a running program
    assert property (@(posedge clk) disable iff (!arstN)
        dataWe |-> (state == cpuPkg::IDLE || state == cpuPkg::HALTED));

endmodule

`default_nettype wire

/* design/instrQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instrQueue (
    input  logic               clk,
    input  logic               arstN,
    input  logic               flush,
    // from fetch
    input  logic               fetchValid,
    input  cpuPkg::queueEntryT fetchEntry,
    output logic               fetchReady,
    // to execute
    output logic               issueValid,
    output cpuPkg::queueEntryT issueEntry,
    input  logic               issueReady
);

    cpuPkg::queueEntryT entries [cpuPkg::queueDepth];

    // depth is a power of two so pointers wrap on their own
    logic [cpuPkg::queuePtrWidth-1:0] wrPtr;
    logic [cpuPkg::queuePtrWidth-1:0] rdPtr;
    logic [cpuPkg::queueCntWidth-1:0] count;
    logic                             push;
    logic                             pop;

    assign fetchReady = (count != cpuPkg::queueDepth);
    assign issueValid = (count != '0);
    // head entry read without a register
    assign issueEntry = entries[rdPtr];

    // flush beats both sides
    assign push = fetchValid && fetchReady && !flush;
    assign pop  = issueValid && issueReady && !flush;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= fetchEntry;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        count <= cpuPkg::queueDepth);

    // full queue without a pop must not take a write
    assert property (@(posedge clk) disable iff (!arstN)
        count == cpuPkg::queueDepth && !pop && !flush |=> count == cpuPkg::queueDepth);

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic               clk,
    input  logic               arstN,
    // host program writes
    input  logic               progWe,
    input  cpuPkg::addrT       progAddr,
    input  cpuPkg::wordT       progData,
    // control from execute
    input  logic               run,
    input  logic               stop,
    input  logic               redirect,
    input  cpuPkg::addrT       redirectAddr,
    // producer side of the queue
    output logic               fetchValid,
    output cpuPkg::queueEntryT fetchEntry,
    input  logic               fetchReady
);

    // program store, 256 words
    cpuPkg::wordT progMem [2**cpuPkg::addrWidth];

    cpuPkg::addrT pc;
    logic         running;
    logic         issue;

    // next read only when the output register is free after this edge
    // run, stop and redirect all cancel the read
    assign issue = running && !run && !stop && !redirect &&
                   (!fetchValid || fetchReady);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            running    <= 1'b0;
            fetchValid <= 1'b0;
        end else if (run) begin
            // program always begins at word 0
            pc         <= '0;
            running    <= 1'b1;
            fetchValid <= 1'b0;
        end else if (stop) begin
            running    <= 1'b0;
            fetchValid <= 1'b0;
        end else if (redirect) begin
            // drop the entry in the output register too
            pc         <= redirectAddr;
            fetchValid <= 1'b0;
        end else if (issue) begin
            pc         <= pc + 1'b1;
            fetchValid <= 1'b1;
        end else if (fetchReady) begin
            // entry taken and nothing new behind it
            fetchValid <= 1'b0;
        end
    end

    // sync read straight into the output register
    // register only loads on issue so a stalled entry holds
    always_ff @(posedge clk) begin
        if (progWe) begin
            progMem[progAddr] <= progData;
        end
        if (issue) begin
            fetchEntry.instr     <= cpuPkg::instrT'(progMem[pc]);
            fetchEntry.fetchAddr <= pc;
        end
    end

    // stalled entry stays put until the queue takes it
    assert property (@(posedge clk) disable iff (!arstN)
        fetchValid && !fetchReady |=> $stable(fetchEntry));

    // valid is only withdrawn by a cancel
    assert property (@(posedge clk) disable iff (!arstN)
        fetchValid && !fetchReady && !run && !stop && !redirect |=> fetchValid);

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpuPkg::aluOpE op,
    input  cpuPkg::wordT  operandA,
    input  cpuPkg::wordT  operandB,
    output cpuPkg::wordT  result
);

    always_comb begin
        result = '0;
        case (op)
            // arithmetic
            cpuPkg::ADD: result = operandA + operandB;
            cpuPkg::SUB: result = operandA - operandB;
            // only the low half of the product is kept
            cpuPkg::MUL: result = operandA * operandB;
            cpuPkg::DIV: begin
                // zero divisor saturates to all ones
                if (operandB == '0) begin
                    result = '1;
                end else begin
                    result = operandA / operandB;
                end
            end
            // single bit shifts on operand a only
            cpuPkg::SHL: result = operandA << 1;
            cpuPkg::SHR: result = operandA >> 1;
            // rotates wrap the edge bit around
            cpuPkg::ROL: result = {operandA[cpuPkg::dataWidth-2:0],
                                   operandA[cpuPkg::dataWidth-1]};
            cpuPkg::ROR: result = {operandA[0],
                                   operandA[cpuPkg::dataWidth-1:1]};
            // bitwise group
            cpuPkg::AND:  result = operandA & operandB;
            cpuPkg::OR:   result = operandA | operandB;
            cpuPkg::XOR:  result = operandA ^ operandB;
            cpuPkg::NOR:  result = ~(operandA | operandB);
            cpuPkg::NAND: result = ~(operandA & operandB);
            cpuPkg::XNOR: result = ~(operandA ^ operandB);
            // compares return 0 or 1, unsigned
            cpuPkg::GT: begin
                if (operandA > operandB) begin
                    result = cpuPkg::wordT'(1);
                end else begin
                    result = '0;
                end
            end
            cpuPkg::EQ: begin
                if (operandA == operandB) begin
                    result = cpuPkg::wordT'(1);
                end else begin
                    result = '0;
                end
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // word and address sizes
    localparam int dataWidth = 16;
    localparam int addrWidth = 8;

    // instruction queue sizing
    localparam int queueDepth = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueCntWidth = $clog2(queueDepth + 1);

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [addrWidth-1:0] addrT;

    // alu operations in the order of the original alu table
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        MUL  = 4'd2,
        DIV  = 4'd3,
        SHL  = 4'd4,
        SHR  = 4'd5,
        ROL  = 4'd6,
        ROR  = 4'd7,
        AND  = 4'd8,
        OR   = 4'd9,
        XOR  = 4'd10,
        NOR  = 4'd11,
        NAND = 4'd12,
        XNOR = 4'd13,
        GT   = 4'd14,
        EQ   = 4'd15
    } aluOpE;

    // machine operations
    // codes 8 to 15 are unused and execute as nop
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LOADI = 4'd1,
        LOAD  = 4'd2,
        STORE = 4'd3,
        ALUM  = 4'd4,
        JUMP  = 4'd5,
        JUMPZ = 4'd6,
        HALT  = 4'd7
    } instrOpE;

    // one program word, op in the top nibble
    typedef struct packed {
        instrOpE op;
        aluOpE   aluOp;
        addrT    field;
    } instrT;

    // queue entry with the fetch address kept for debug
    typedef struct packed {
        instrT instr;
        addrT  fetchAddr;
    } queueEntryT;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RUN     = 2'd1,
        MEMWAIT = 2'd2,
        HALTED  = 2'd3
    } execStateE;

endpackage

`default_nettype wire
